// ==== sim.f ====
source/core_pkg.sv
source/instr_mem.sv
source/decoder.sv
source/reg_file.sv
source/alu.sv
source/data_mem.sv
source/led_csr.sv
source/top_core.sv
verification/top_core_sva.sv
verification/tb_top_core.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_top_core -f sim.f \
  -o tb_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "TESTBENCH PASSED" sim.log && ! grep -q "TESTBENCH FAILED" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verification/tb_top_core.sv ====
// testbench for top_core: clock, reset, program loading, reference model, led comparison, report
module tb_top_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int led_width    = 8;
  localparam int imem_depth   = 2**core_pkg::ImemAddrWidth;
  localparam int dmem_depth   = 2**core_pkg::DmemAddrWidth;
  localparam int reset_cycles = 2;
  localparam int run_cycles   = 48;
  localparam int random_runs  = 4;
  localparam int test_count   = 5 + random_runs;
  // load, reset, run and a few edges of hand-over per test, then a margin
  localparam int cycle_limit  = test_count * (imem_depth + reset_cycles + run_cycles + 4) + 100;
  localparam int led_addr     = 12'h7C0;
  localparam int other_csr    = 12'h340;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 imem_write_enable;
  core_pkg::imem_addr_t imem_write_addr;
  core_pkg::word_t      imem_write_data;
  logic [led_width-1:0] led;

  // program image shared by the loader and the model
  core_pkg::word_t      prog [imem_depth];
  int                   fill;
  logic                 checking = 1'b0;
  int                   step_count = 0;
  logic [led_width-1:0] expected_led;
  int                   errors = 0;
  int                   test_errors = 0;
  int                   tests_run = 0;
  int                   tests_passed = 0;
  int                   cycle_count = 0;

  top_core #(
    .led_width(led_width)
  ) top_core_i (
    .clk              (clk),
    .reset            (reset),
    .imem_write_enable(imem_write_enable),
    .imem_write_addr  (imem_write_addr),
    .imem_write_data  (imem_write_data),
    .led              (led)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // instruction encoders, rv32i field layout
  function automatic core_pkg::word_t r_type(input int f7, input int f3, input int rd,
                                             input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic core_pkg::word_t i_type(input int opc, input int f3, input int rd,
                                             input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic core_pkg::word_t s_type(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
  endfunction

  // imm in bytes, four per word
  function automatic core_pkg::word_t b_type(input int f3, input int rs1, input int rs2,
                                             input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic core_pkg::word_t u_type(input int rd, input int upper);
    return {upper[19:0], rd[4:0], 7'h37};
  endfunction

  function automatic core_pkg::word_t j_type(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic core_pkg::word_t csrrw_word(input int rd, input int csr, input int rs1);
    return {csr[11:0], rs1[4:0], 3'b001, rd[4:0], 7'h73};
  endfunction

  // 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt
  function automatic core_pkg::word_t alu_instr(input int k, input int rd, input int rs1,
                                                input int rs2);
    case (k)
      0:       return r_type(0, 0, rd, rs1, rs2);
      1:       return r_type(7'h20, 0, rd, rs1, rs2);
      2:       return r_type(0, 7, rd, rs1, rs2);
      3:       return r_type(0, 6, rd, rs1, rs2);
      4:       return r_type(0, 4, rd, rs1, rs2);
      default: return r_type(0, 2, rd, rs1, rs2);
    endcase
  endfunction

  // funct3 values the core implements for alu ops
  function automatic logic funct_ok(input logic [2:0] f3);
    return f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
  endfunction

  function automatic core_pkg::word_t alu_ref(input logic [2:0] f3, input logic is_sub,
                                              input core_pkg::word_t a, input core_pkg::word_t b);
    case (f3)
      3'b000:  return is_sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // executes prog for a number of retired instructions, word pc, returns the led value
  function automatic logic [led_width-1:0] run_model(input int steps);
    core_pkg::word_t      x [32];
    core_pkg::word_t      mem [dmem_depth];
    core_pkg::imem_addr_t pc;
    core_pkg::imem_addr_t next_pc;
    logic [led_width-1:0] led_val;
    core_pkg::word_t      ins;
    core_pkg::word_t      a;
    core_pkg::word_t      b;
    core_pkg::word_t      imm_i;
    core_pkg::word_t      imm_s;
    core_pkg::word_t      imm_b;
    core_pkg::word_t      imm_j;
    core_pkg::word_t      res;
    logic                 wr;
    logic [2:0]           f3;
    logic [6:0]           f7;
    x = '{default: '0};
    mem = '{default: '0};
    pc = '0;
    led_val = '0;
    for (int s = 0; s < steps; s++) begin
      ins = prog[pc];
      a = x[ins[19:15]];
      b = x[ins[24:20]];
      f3 = ins[14:12];
      f7 = ins[31:25];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      next_pc = core_pkg::imem_addr_t'(pc + 1);
      wr = 1'b0;
      res = '0;
      case (ins[6:0])
        7'h13: if (funct_ok(f3)) begin
          wr = 1'b1;
          res = alu_ref(f3, 1'b0, a, imm_i);
        end
        7'h33: if (funct_ok(f3) && (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000))) begin
          wr = 1'b1;
          res = alu_ref(f3, f7[5], a, b);
        end
        7'h37: begin
          wr = 1'b1;
          res = {ins[31:12], 12'b0};
        end
        // word index is the low bits of the address sum
        7'h03: if (f3 == 3'b010) begin
          wr = 1'b1;
          res = mem[core_pkg::dmem_addr_t'(a + imm_i)];
        end
        7'h23: if (f3 == 3'b010) begin
          mem[core_pkg::dmem_addr_t'(a + imm_s)] = b;
        end
        7'h63: if (f3[2:1] == 2'b00 && ((a == b) != f3[0])) begin
          next_pc = core_pkg::imem_addr_t'(core_pkg::word_t'(pc) + (imm_b >> 2));
        end
        7'h6f: begin
          wr = 1'b1;
          res = core_pkg::word_t'(next_pc);
          next_pc = core_pkg::imem_addr_t'(core_pkg::word_t'(pc) + (imm_j >> 2));
        end
        // only the led csr exists, anything else reads zero
        7'h73: if (f3 == 3'b001) begin
          wr = 1'b1;
          if (ins[31:20] == 12'(led_addr)) begin
            res = core_pkg::word_t'(led_val);
            led_val = a[led_width-1:0];
          end
        end
        default: ;
      endcase
      if (wr && ins[11:7] != 5'd0) begin
        x[ins[11:7]] = res;
      end
      pc = next_pc;
    end
    return led_val;
  endfunction

  task automatic clear_program();
    prog = '{default: '0};
    fill = 0;
  endtask

  task automatic emit(input core_pkg::word_t w);
    if (fill < imem_depth) begin
      prog[fill] = w;
      fill++;
    end
  endtask

  // lui then addi, upper part rounded for the sign of the low 12 bits
  task automatic load_constant(input int rd, input core_pkg::word_t value);
    core_pkg::word_t upper;
    upper = (value + 32'h800) >> 12;
    emit(u_type(rd, int'(upper)));
    emit(i_type(7'h13, 0, rd, rd, int'(value[11:0])));
  endtask

  task automatic build_arith_program();
    clear_program();
    for (int p = 0; p < 2; p++) begin
      load_constant(1, $urandom);
      load_constant(2, $urandom);
      for (int k = 0; k < 6; k++) begin
        emit(alu_instr(k, 3, 1, 2));
        emit(csrrw_word(0, led_addr, 3));
      end
    end
  endtask

  task automatic build_memory_program();
    clear_program();
    for (int r = 1; r <= 4; r++) begin
      load_constant(r, $urandom);
    end
    // base 5, words 8, 13, 21 and 40
    emit(i_type(7'h13, 0, 9, 0, 5));
    emit(s_type(1, 9, 3));
    emit(s_type(2, 9, 8));
    emit(s_type(3, 9, 16));
    emit(s_type(4, 9, 35));
    // read back in another order
    emit(i_type(7'h03, 2, 5, 9, 35));
    emit(i_type(7'h03, 2, 6, 9, 3));
    emit(i_type(7'h03, 2, 7, 9, 16));
    emit(i_type(7'h03, 2, 8, 9, 8));
    emit(csrrw_word(0, led_addr, 7));
    emit(alu_instr(0, 10, 5, 6));
    emit(csrrw_word(0, led_addr, 10));
    emit(alu_instr(0, 10, 10, 7));
    emit(csrrw_word(0, led_addr, 10));
    emit(alu_instr(0, 10, 10, 8));
    emit(csrrw_word(0, led_addr, 10));
  endtask

  task automatic build_loop_program();
    clear_program();
    emit(i_type(7'h13, 0, 1, 0, 5));
    emit(i_type(7'h13, 0, 2, 0, 0));
    // loop body at word 2, back one word while x2 != x1
    emit(i_type(7'h13, 0, 2, 2, 1));
    emit(b_type(1, 2, 1, -4));
    // beq x2, x0 never taken here
    emit(b_type(0, 2, 0, 8));
    emit(csrrw_word(0, led_addr, 2));
    // jal over one word, link lands in x3
    emit(j_type(3, 8));
    emit(i_type(7'h13, 0, 2, 0, 99));
    emit(csrrw_word(0, led_addr, 3));
    emit(csrrw_word(0, led_addr, 2));
  endtask

  task automatic build_csr_program();
    clear_program();
    emit(i_type(7'h13, 0, 1, 0, 8'h5A));
    emit(csrrw_word(0, led_addr, 1));
    emit(i_type(7'h13, 0, 2, 0, 8'h33));
    emit(csrrw_word(3, led_addr, 2));
    // other address, led must stay put
    emit(csrrw_word(4, other_csr, 1));
    emit(csrrw_word(0, led_addr, 3));
    emit(csrrw_word(5, led_addr, 4));
    emit(csrrw_word(0, led_addr, 5));
  endtask

  // forward branches and jumps only, a few words at most
  task automatic build_random_program(input int length);
    int pick;
    int rd;
    int rs1;
    int rs2;
    int off;
    clear_program();
    for (int i = 0; i < length; i++) begin
      pick = $urandom_range(7);
      rd = $urandom_range(7);
      rs1 = $urandom_range(7);
      rs2 = $urandom_range(7);
      off = $urandom_range(4, 1);
      case (pick)
        0:       emit(i_type(7'h13, 0, rd, rs1, int'($urandom)));
        1:       emit(u_type(rd, int'($urandom)));
        2, 3:    emit(alu_instr($urandom_range(5), rd, rs1, rs2));
        4:       emit(b_type($urandom_range(1), rs1, rs2, off * 4));
        5:       emit(j_type(rd, off * 4));
        default: emit(csrrw_word(rd, ($urandom_range(3) == 0) ? other_csr : led_addr, rs1));
      endcase
    end
  endtask

  // load under reset on falling edges, then run with a check after every retire
  task automatic run_test(input string name, input int cycles);
    @(negedge clk);
    reset = 1'b1;
    test_errors = 0;
    for (int i = 0; i < imem_depth; i++) begin
      imem_write_enable = 1'b1;
      imem_write_addr = core_pkg::imem_addr_t'(i);
      imem_write_data = prog[i];
      @(negedge clk);
    end
    imem_write_enable = 1'b0;
    repeat (reset_cycles) @(negedge clk);
    // step 0 checks the reset state
    @(posedge clk);
    step_count = 0;
    checking = 1'b1;
    @(negedge clk);
    reset = 1'b0;
    for (int k = 1; k <= cycles; k++) begin
      @(posedge clk);
      step_count = k;
    end
    @(posedge clk);
    checking = 1'b0;
    tests_run++;
    if (test_errors == 0) begin
      tests_passed++;
    end
    $display("test %s: %0d steps, %0d mismatches", name, cycles, test_errors);
  endtask

  // led only moves on rising edges, sampled in the middle of the cycle
  always @(negedge clk) begin
    if (checking) begin
      expected_led = run_model(step_count);
      assert (led === expected_led) else begin
        $display("mismatch at %0t: led expected %h, got %h, step %0d",
                 $time, expected_led, led, step_count);
        errors++;
        test_errors++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    imem_write_enable = 1'b0;
    imem_write_addr = '0;
    imem_write_data = '0;
    void'($urandom(32'h2429));
    clear_program();
    run_test("reset and nop", run_cycles);
    build_arith_program();
    run_test("alu ops", run_cycles);
    build_memory_program();
    run_test("memory", run_cycles);
    build_loop_program();
    run_test("control flow", run_cycles);
    build_csr_program();
    run_test("csr", run_cycles);
    for (int r = 0; r < random_runs; r++) begin
      build_random_program(40);
      run_test($sformatf("random %0d", r), run_cycles);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
             tests_run, tests_passed, tests_run - tests_passed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/top_core_sva.sv ====
// concurrent assertions on pc stepping after reset and x0 reads, bound into top_core
module top_core_sva (
  input logic                 clk,
  input logic                 reset,
  input core_pkg::imem_addr_t pc,
  input core_pkg::word_t      instr,
  input core_pkg::reg_idx_t   rs1,
  input core_pkg::reg_idx_t   rs2,
  input core_pkg::word_t      rs1_data,
  input core_pkg::word_t      rs2_data
);
  timeunit 1ns;
  timeprecision 1ps;

  // pc restarts at word 0
  pc_after_reset: assert property (@(posedge clk) reset |=> pc == '0)
    else $error("pc not zero in the cycle after reset");

  // anything but a branch or jal moves one word, wrapping at the top
  pc_sequential: assert property (@(posedge clk)
    (!reset && instr[6:0] != core_pkg::op_branch && instr[6:0] != core_pkg::op_jal)
      |=> pc == $past(pc) + core_pkg::imem_addr_t'(1))
    else $error("pc did not advance by one word");

  // x0 on both read ports
  x0_port1: assert property (@(posedge clk) (!reset && rs1 == '0) |-> rs1_data == '0)
    else $error("x0 read nonzero on port 1");
  x0_port2: assert property (@(posedge clk) (!reset && rs2 == '0) |-> rs2_data == '0)
    else $error("x0 read nonzero on port 2");

endmodule

bind top_core top_core_sva sva_i (
  .clk     (clk),
  .reset   (reset),
  .pc      (pc),
  .instr   (instr),
  .rs1     (rs1),
  .rs2     (rs2),
  .rs1_data(rs1_data),
  .rs2_data(rs2_data)
);

// ==== source/top_core.sv ====
// top_core: pc register, branch and next-pc logic, operand and write-back muxes, block instances
module top_core #(
  parameter int led_width = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 imem_write_enable,
  input  core_pkg::imem_addr_t imem_write_addr,
  input  core_pkg::word_t      imem_write_data,
  output logic [led_width-1:0] led
);

  core_pkg::imem_addr_t pc;
  core_pkg::imem_addr_t pc_plus_1;
  core_pkg::imem_addr_t pc_branch;
  core_pkg::imem_addr_t pc_next;
  logic                 branch_taken;
  logic                 rs_equal;

  core_pkg::word_t      instr;
  core_pkg::ctrl_t      ctrl;
  core_pkg::reg_idx_t   rs1;
  core_pkg::reg_idx_t   rs2;
  core_pkg::reg_idx_t   rd;
  core_pkg::word_t      imm;
  core_pkg::csr_addr_t  csr_addr;

  core_pkg::word_t      rs1_data;
  core_pkg::word_t      rs2_data;
  core_pkg::word_t      alu_b;
  core_pkg::word_t      alu_result;
  core_pkg::word_t      dmem_data;
  core_pkg::word_t      csr_data;
  core_pkg::word_t      wb_data;
  logic                 dmem_write;

  // pc counts words
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // byte offset to word offset
  assign pc_plus_1 = pc + 1'b1;
  assign pc_branch = pc + imm[core_pkg::ImemAddrWidth+1:2];

  // beq / bne on equality, jal always
  assign rs_equal     = (rs1_data == rs2_data);
  assign branch_taken = (ctrl.branch && (rs_equal ^ ctrl.branch_ne)) || ctrl.jump;
  assign pc_next      = branch_taken ? pc_branch : pc_plus_1;

  instr_mem imem (
    .clk,
    .write_enable(imem_write_enable),
    .write_addr  (imem_write_addr),
    .write_data  (imem_write_data),
    .addr        (pc),
    .data        (instr)
  );

  decoder dec (
    .instr,
    .ctrl,
    .rs1,
    .rs2,
    .rd,
    .imm,
    .csr_addr
  );

  reg_file rf (
    .clk,
    .reset,
    .write_enable(ctrl.reg_write),
    .write_addr  (rd),
    .write_data  (wb_data),
    .read_addr1  (rs1),
    .read_addr2  (rs2),
    .read_data1  (rs1_data),
    .read_data2  (rs2_data)
  );

  // operand b
  assign alu_b = (ctrl.alu_b_sel == core_pkg::b_imm) ? imm : rs2_data;

  alu alu_i (
    .a     (rs1_data),
    .b     (alu_b),
    .op    (ctrl.alu_op),
    .result(alu_result)
  );

  // no stores while the program is loading
  assign dmem_write = ctrl.dmem_write && !reset;

  // alu result is the word index
  data_mem dmem (
    .clk,
    .write_enable(dmem_write),
    .addr        (alu_result[core_pkg::DmemAddrWidth-1:0]),
    .write_data  (rs2_data),
    .read_data   (dmem_data)
  );

  led_csr #(
    .led_width(led_width)
  ) led_csr_i (
    .clk,
    .reset,
    .csr_write (ctrl.csr_write),
    .csr_addr,
    .write_data(rs1_data),
    .read_data (csr_data),
    .led
  );

  // write back, link value in words
  always_comb begin
    case (ctrl.wb_sel)
      core_pkg::wb_dmem:      wb_data = dmem_data;
      core_pkg::wb_pc_plus_1: wb_data = core_pkg::word_t'(pc_plus_1);
      core_pkg::wb_csr:       wb_data = csr_data;
      default:                wb_data = alu_result;
    endcase
  end

endmodule

// ==== source/led_csr.sv ====
// led csr: led_width-bit register at the led csr address, csrrw returns the old value
module led_csr #(
  parameter int led_width = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 csr_write,
  input  core_pkg::csr_addr_t  csr_addr,
  input  core_pkg::word_t      write_data,
  output core_pkg::word_t      read_data,
  output logic [led_width-1:0] led
);

  logic                 hit;
  logic [led_width-1:0] led_reg;

  assign hit = (csr_addr == core_pkg::led_csr_addr);

  // new value from rs1, low bits only
  always_ff @(posedge clk) begin
    if (reset) begin
      led_reg <= '0;
    end else if (csr_write && hit) begin
      led_reg <= write_data[led_width-1:0];
    end
  end

  // old value, zero extended, other addresses read zero
  assign read_data = hit ? core_pkg::word_t'(led_reg) : '0;
  assign led       = led_reg;

endmodule

// ==== source/data_mem.sv ====
// data memory: word-addressed, synchronous write, combinational read
module data_mem (
  input  logic                 clk,
  input  logic                 write_enable,
  input  core_pkg::dmem_addr_t addr,
  input  core_pkg::word_t      write_data,
  output core_pkg::word_t      read_data
);

  // word storage only, no byte lanes
  core_pkg::word_t mem [2**core_pkg::DmemAddrWidth];

  // sw lands on the retiring edge
  always_ff @(posedge clk) begin
    if (write_enable) begin
      mem[addr] <= write_data;
    end
  end

  // lw reads in the same cycle
  assign read_data = mem[addr];

endmodule

// ==== source/alu.sv ====
// alu: add, sub, and, or, xor, signed slt and pass of operand b
module alu (
  input  core_pkg::word_t   a,
  input  core_pkg::word_t   b,
  input  core_pkg::alu_op_t op,
  output core_pkg::word_t   result
);

  always_comb begin
    case (op)
      core_pkg::alu_add:    result = a + b;
      core_pkg::alu_sub:    result = a - b;
      core_pkg::alu_and:    result = a & b;
      core_pkg::alu_or:     result = a | b;
      core_pkg::alu_xor:    result = a ^ b;
      // signed compare, 0 or 1
      core_pkg::alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
      // lui
      core_pkg::alu_pass_b: result = b;
      default:              result = '0;
    endcase
  end

endmodule

// ==== source/reg_file.sv ====
// register file: 32 x 32, two combinational reads, one synchronous write, x0 fixed at zero
module reg_file (
  input  logic                clk,
  input  logic                reset,
  input  logic                write_enable,
  input  core_pkg::reg_idx_t  write_addr,
  input  core_pkg::word_t     write_data,
  input  core_pkg::reg_idx_t  read_addr1,
  input  core_pkg::reg_idx_t  read_addr2,
  output core_pkg::word_t     read_data1,
  output core_pkg::word_t     read_data2
);

  core_pkg::word_t regs [32];

  // whole file cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (write_enable && write_addr != '0) begin
      // x0 never written, so it stays zero
      regs[write_addr] <= write_data;
    end
  end

  // read ports
  assign read_data1 = regs[read_addr1];
  assign read_data2 = regs[read_addr2];

endmodule

// ==== source/decoder.sv ====
// decoder: instruction word to control struct, register indices, immediate and csr address
module decoder (
  input  core_pkg::word_t     instr,
  output core_pkg::ctrl_t     ctrl,
  output core_pkg::reg_idx_t  rs1,
  output core_pkg::reg_idx_t  rs2,
  output core_pkg::reg_idx_t  rd,
  output core_pkg::word_t     imm,
  output core_pkg::csr_addr_t csr_addr
);

  core_pkg::opcode_t opcode;
  logic [2:0]        funct3;
  logic              funct7_alt;
  logic              funct7_zero;
  core_pkg::alu_op_t op_from_funct;
  logic              funct_valid;
  core_pkg::word_t   imm_i;
  core_pkg::word_t   imm_s;
  core_pkg::word_t   imm_b;
  core_pkg::word_t   imm_u;
  core_pkg::word_t   imm_j;

  assign opcode      = core_pkg::opcode_t'(instr[6:0]);
  assign funct3      = instr[14:12];
  // bit 30 picks sub, every other funct7 bit must be clear
  assign funct7_alt  = instr[30];
  assign funct7_zero = (instr[31] == 1'b0) && (instr[29:25] == 5'b0);

  // register fields sit at fixed positions
  assign rs1      = instr[19:15];
  assign rs2      = instr[24:20];
  assign rd       = instr[11:7];
  assign csr_addr = instr[31:20];

  // immediate formats, all sign extended
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3 to alu op, shared by the register and immediate forms
  always_comb begin
    op_from_funct = core_pkg::alu_add;
    funct_valid   = 1'b1;
    case (funct3)
      3'b000: begin
        if (opcode == core_pkg::op_reg && funct7_alt) begin
          op_from_funct = core_pkg::alu_sub;
        end
      end
      3'b010:  op_from_funct = core_pkg::alu_slt;
      3'b100:  op_from_funct = core_pkg::alu_xor;
      3'b110:  op_from_funct = core_pkg::alu_or;
      3'b111:  op_from_funct = core_pkg::alu_and;
      // shifts and sltu not supported
      default: funct_valid = 1'b0;
    endcase
    // register form: only sub may set bit 30
    if (opcode == core_pkg::op_reg) begin
      if (!funct7_zero || (funct7_alt && funct3 != 3'b000)) begin
        funct_valid = 1'b0;
      end
    end
  end

  // control per opcode, anything unknown stays all zero
  always_comb begin
    ctrl = '0;
    imm  = '0;
    case (opcode)
      core_pkg::op_imm: begin
        imm = imm_i;
        if (funct_valid) begin
          ctrl.alu_op    = op_from_funct;
          ctrl.alu_b_sel = core_pkg::b_imm;
          ctrl.reg_write = 1'b1;
        end
      end
      core_pkg::op_reg: begin
        if (funct_valid) begin
          ctrl.alu_op    = op_from_funct;
          ctrl.reg_write = 1'b1;
        end
      end
      core_pkg::op_lui: begin
        // upper immediate straight through the alu
        imm            = imm_u;
        ctrl.alu_op    = core_pkg::alu_pass_b;
        ctrl.alu_b_sel = core_pkg::b_imm;
        ctrl.reg_write = 1'b1;
      end
      core_pkg::op_load: begin
        imm = imm_i;
        // lw only
        if (funct3 == 3'b010) begin
          ctrl.alu_b_sel = core_pkg::b_imm;
          ctrl.wb_sel    = core_pkg::wb_dmem;
          ctrl.reg_write = 1'b1;
        end
      end
      core_pkg::op_store: begin
        imm = imm_s;
        // sw only
        if (funct3 == 3'b010) begin
          ctrl.alu_b_sel  = core_pkg::b_imm;
          ctrl.dmem_write = 1'b1;
        end
      end
      core_pkg::op_branch: begin
        imm = imm_b;
        // beq 000, bne 001
        if (funct3[2:1] == 2'b00) begin
          ctrl.branch    = 1'b1;
          ctrl.branch_ne = funct3[0];
        end
      end
      core_pkg::op_jal: begin
        imm            = imm_j;
        ctrl.jump      = 1'b1;
        ctrl.wb_sel    = core_pkg::wb_pc_plus_1;
        ctrl.reg_write = 1'b1;
      end
      core_pkg::op_system: begin
        // csrrw, old value to rd
        if (funct3 == 3'b001) begin
          ctrl.wb_sel    = core_pkg::wb_csr;
          ctrl.reg_write = 1'b1;
          ctrl.csr_write = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== source/instr_mem.sv ====
// instruction memory: combinational read port and a load port for program download
module instr_mem (
  input  logic                   clk,
  input  logic                   write_enable,
  input  core_pkg::imem_addr_t   write_addr,
  input  core_pkg::word_t        write_data,
  input  core_pkg::imem_addr_t   addr,
  output core_pkg::word_t        data
);

  // zero words decode as nop
  core_pkg::word_t mem [2**core_pkg::ImemAddrWidth] = '{default: '0};

  // program load, one word per edge
  always_ff @(posedge clk) begin
    if (write_enable) begin
      mem[write_addr] <= write_data;
    end
  end

  // fetch, no latency
  assign data = mem[addr];

endmodule

// ==== source/core_pkg.sv ====
// core package: memory widths, vector typedefs, opcode and control enums, decoded control struct
package core_pkg;

  // word address widths of the two memories
  parameter int ImemAddrWidth = 6;
  parameter int DmemAddrWidth = 6;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [ImemAddrWidth-1:0] imem_addr_t;
  typedef logic [DmemAddrWidth-1:0] dmem_addr_t;
  typedef logic [11:0] csr_addr_t;

  // the one csr the core implements
  parameter csr_addr_t led_csr_addr = 12'h7C0;

  // rv32i major opcodes in use
  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_imm    = 7'b0010011,
    op_store  = 7'b0100011,
    op_reg    = 7'b0110011,
    op_lui    = 7'b0110111,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_system = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_t;

  typedef enum logic {
    b_rs2,
    b_imm
  } alu_b_sel_t;

  typedef enum logic [1:0] {
    wb_alu,
    wb_dmem,
    wb_pc_plus_1,
    wb_csr
  } wb_sel_t;

  // all zero means nop
  typedef struct packed {
    alu_op_t    alu_op;
    alu_b_sel_t alu_b_sel;
    wb_sel_t    wb_sel;
    logic       reg_write;
    logic       dmem_write;
    logic       branch;
    logic       branch_ne;
    logic       jump;
    logic       csr_write;
  } ctrl_t;

endpackage
